/* src/rv_defs.svh */
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Data path and address width
`define RV_XLEN 32

// Memory depths in 32-bit words
`define RV_IMEM_WORDS 256
`define RV_DMEM_WORDS 64

// First fetch address out of reset
`define RV_RESET_PC 32'h0000_0000

`endif

/* src/rv_isa_pkg.sv */
package rv_isa_pkg;

  // Major opcodes, instr[6:0]
  localparam logic [6:0] OP_ARITH     = 7'b0110011;
  localparam logic [6:0] OP_ARITH_IMM = 7'b0010011;
  localparam logic [6:0] OP_LOAD      = 7'b0000011;
  localparam logic [6:0] OP_STORE     = 7'b0100011;
  localparam logic [6:0] OP_BRANCH    = 7'b1100011;
  localparam logic [6:0] OP_JAL       = 7'b1101111;
  localparam logic [6:0] OP_JALR      = 7'b1100111;

  // funct3 for arithmetic and logic
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_SLL = 3'b001;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_SRL = 3'b101;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;

  // funct3 for conditional branches
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;
  localparam logic [2:0] F3_BLT = 3'b100;
  localparam logic [2:0] F3_BGE = 3'b101;

  localparam logic [6:0] F7_SUB = 7'b0100000;

endpackage

/* src/rv_ctrl_pkg.sv */
package rv_ctrl_pkg;

  // Codes follow funct3 where one exists, SUB takes a spare slot
  typedef enum logic [2:0] {
    ALU_ADD = 3'b000,
    ALU_SLL = 3'b001,
    ALU_SUB = 3'b010,
    ALU_XOR = 3'b100,
    ALU_SRL = 3'b101,
    ALU_OR  = 3'b110,
    ALU_AND = 3'b111
  } alu_op_t;

  typedef enum logic {SRC_REG, SRC_IMM} alu_src_t;

  // Writeback source
  typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_sel_t;

  // Kind of control transfer
  typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JAL, PC_JALR} pc_sel_t;

endpackage

/* src/rv_fetch.sv */
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_fetch (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             run,
  input  logic                             load_en,
  input  logic [$clog2(`RV_IMEM_WORDS)-1:0] load_addr,  // Word index
  input  logic [`RV_XLEN-1:0]              load_data,
  input  logic [`RV_XLEN-1:0]              next_pc,
  output logic [`RV_XLEN-1:0]              pc,
  output logic [`RV_XLEN-1:0]              pc_plus4,
  output logic [`RV_XLEN-1:0]              instr
);

  localparam int IMEM_AW = $clog2(`RV_IMEM_WORDS);

  logic [`RV_XLEN-1:0] imem [`RV_IMEM_WORDS];

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= `RV_RESET_PC;
    end else if (run) begin
      pc <= next_pc;
    end
  end

  // Loader port, used while the core is stopped
  always_ff @(posedge clk) begin
    if (load_en) begin
      imem[load_addr] <= load_data;
    end
  end

  assign pc_plus4 = pc + `RV_XLEN'd4;
  assign instr    = imem[pc[IMEM_AW+1:2]];  // Byte address to word index

  // Branch, JAL and JALR targets must keep the PC on a word boundary
  pc_aligned_a: assert property (@(posedge clk) disable iff (reset)
    pc[1:0] == 2'b00);

endmodule

/* src/rv_decode.sv */
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_decode (
  input  logic [`RV_XLEN-1:0]   instr,
  output logic [4:0]            rs1,
  output logic [4:0]            rs2,
  output logic [4:0]            rd,
  output logic [2:0]            funct3,
  output logic [`RV_XLEN-1:0]   imm,
  output rv_ctrl_pkg::alu_op_t  alu_op,
  output rv_ctrl_pkg::alu_src_t alu_src,
  output rv_ctrl_pkg::wb_sel_t  wb_sel,
  output rv_ctrl_pkg::pc_sel_t  pc_sel,
  output logic                  reg_we,
  output logic                  mem_we
);

  logic [6:0] opcode;
  logic [6:0] funct7;
  logic [1:0] alu_class;  // 0 add, 1 sub, 2 from funct fields

  assign opcode = instr[6:0];
  assign funct7 = instr[31:25];
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign rd     = instr[11:7];

  // Main control
  always_comb begin
    alu_class = 2'd0;
    alu_src   = rv_ctrl_pkg::SRC_REG;
    wb_sel    = rv_ctrl_pkg::WB_ALU;
    pc_sel    = rv_ctrl_pkg::PC_SEQ;
    reg_we    = 1'b0;
    mem_we    = 1'b0;
    case (opcode)
      rv_isa_pkg::OP_ARITH: begin
        alu_class = 2'd2;
        reg_we    = 1'b1;
      end
      rv_isa_pkg::OP_ARITH_IMM: begin
        alu_class = 2'd2;
        alu_src   = rv_ctrl_pkg::SRC_IMM;
        reg_we    = 1'b1;
      end
      rv_isa_pkg::OP_LOAD: begin
        alu_src = rv_ctrl_pkg::SRC_IMM;
        wb_sel  = rv_ctrl_pkg::WB_MEM;
        reg_we  = 1'b1;
      end
      rv_isa_pkg::OP_STORE: begin
        alu_src = rv_ctrl_pkg::SRC_IMM;
        mem_we  = 1'b1;
      end
      rv_isa_pkg::OP_BRANCH: begin
        alu_class = 2'd1;  // Compare by subtraction
        pc_sel    = rv_ctrl_pkg::PC_BRANCH;
      end
      rv_isa_pkg::OP_JAL: begin
        wb_sel = rv_ctrl_pkg::WB_PC4;
        pc_sel = rv_ctrl_pkg::PC_JAL;
        reg_we = 1'b1;
      end
      rv_isa_pkg::OP_JALR: begin
        alu_src = rv_ctrl_pkg::SRC_IMM;
        wb_sel  = rv_ctrl_pkg::WB_PC4;
        pc_sel  = rv_ctrl_pkg::PC_JALR;
        reg_we  = 1'b1;
      end
      default: ;
    endcase
  end

  // ALU control, second level
  always_comb begin
    case (alu_class)
      2'd1: alu_op = rv_ctrl_pkg::ALU_SUB;
      2'd2: begin
        if (opcode == rv_isa_pkg::OP_ARITH && funct7 == rv_isa_pkg::F7_SUB) begin
          alu_op = rv_ctrl_pkg::ALU_SUB;
        end else begin
          case (funct3)
            rv_isa_pkg::F3_SLL: alu_op = rv_ctrl_pkg::ALU_SLL;
            rv_isa_pkg::F3_XOR: alu_op = rv_ctrl_pkg::ALU_XOR;
            rv_isa_pkg::F3_SRL: alu_op = rv_ctrl_pkg::ALU_SRL;
            rv_isa_pkg::F3_OR:  alu_op = rv_ctrl_pkg::ALU_OR;
            rv_isa_pkg::F3_AND: alu_op = rv_ctrl_pkg::ALU_AND;
            default:            alu_op = rv_ctrl_pkg::ALU_ADD;
          endcase
        end
      end
      default: alu_op = rv_ctrl_pkg::ALU_ADD;
    endcase
  end

  // Immediate generator
  always_comb begin
    case (opcode)
      rv_isa_pkg::OP_ARITH_IMM, rv_isa_pkg::OP_LOAD, rv_isa_pkg::OP_JALR:
        imm = {{21{instr[31]}}, instr[30:20]};
      rv_isa_pkg::OP_STORE:
        imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
      rv_isa_pkg::OP_BRANCH:
        imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      rv_isa_pkg::OP_JAL:
        imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      default:
        imm = '0;
    endcase
  end

endmodule

/* src/rv_regfile.sv */
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_regfile (
  input  logic               clk,
  input  logic               reset,
  input  logic [4:0]         rs1,
  input  logic [4:0]         rs2,
  input  logic [4:0]         rd,
  input  logic               reg_we,
  input  logic [`RV_XLEN-1:0] wb_data,
  output logic [`RV_XLEN-1:0] rs1_val,
  output logic [`RV_XLEN-1:0] rs2_val
);

  logic [`RV_XLEN-1:0] regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_we && rd != 5'd0) begin  // x0 stays zero
      regs[rd] <= wb_data;
    end
  end

  assign rs1_val = regs[rs1];
  assign rs2_val = regs[rs2];

  // x0 never picks up a writeback after reset
  x0_read_zero_a: assert property (@(posedge clk) disable iff (reset)
    (rs1 == 5'd0 |-> rs1_val == '0) and (rs2 == 5'd0 |-> rs2_val == '0));

endmodule

/* src/rv_execute.sv */
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_execute (
  input  logic [`RV_XLEN-1:0]   pc,
  input  logic [`RV_XLEN-1:0]   pc_plus4,
  input  logic [`RV_XLEN-1:0]   imm,
  input  logic [`RV_XLEN-1:0]   rs1_val,
  input  logic [`RV_XLEN-1:0]   rs2_val,
  input  rv_ctrl_pkg::alu_op_t  alu_op,
  input  rv_ctrl_pkg::alu_src_t alu_src,
  input  logic [2:0]            funct3,
  input  rv_ctrl_pkg::pc_sel_t  pc_sel,
  output logic [`RV_XLEN-1:0]   alu_result,
  output logic [`RV_XLEN-1:0]   next_pc
);

  logic [`RV_XLEN-1:0] op_b;
  logic [`RV_XLEN-1:0] pc_target;
  logic                take_branch;

  assign op_b = (alu_src == rv_ctrl_pkg::SRC_IMM) ? imm : rs2_val;

  always_comb begin
    alu_result  = '0;
    take_branch = 1'b0;
    case (alu_op)
      rv_ctrl_pkg::ALU_ADD: alu_result = rs1_val + op_b;
      rv_ctrl_pkg::ALU_SUB: begin
        alu_result = rs1_val - op_b;
        // BLT/BGE only look at the sign of the difference
        case (funct3)
          rv_isa_pkg::F3_BEQ: take_branch = (alu_result == '0);
          rv_isa_pkg::F3_BNE: take_branch = (alu_result != '0);
          rv_isa_pkg::F3_BLT: take_branch = alu_result[`RV_XLEN-1];
          rv_isa_pkg::F3_BGE: take_branch = !alu_result[`RV_XLEN-1];
          default:            take_branch = 1'b0;
        endcase
      end
      rv_ctrl_pkg::ALU_SLL: alu_result = rs1_val << op_b[4:0];
      rv_ctrl_pkg::ALU_XOR: alu_result = rs1_val ^ op_b;
      rv_ctrl_pkg::ALU_SRL: alu_result = rs1_val >> op_b[4:0];
      rv_ctrl_pkg::ALU_OR:  alu_result = rs1_val | op_b;
      rv_ctrl_pkg::ALU_AND: alu_result = rs1_val & op_b;
      default:              alu_result = '0;
    endcase
  end

  assign pc_target = pc + imm;  // Branch and JAL

  always_comb begin
    case (pc_sel)
      rv_ctrl_pkg::PC_BRANCH: next_pc = take_branch ? pc_target : pc_plus4;
      rv_ctrl_pkg::PC_JAL:    next_pc = pc_target;
      rv_ctrl_pkg::PC_JALR:   next_pc = {alu_result[`RV_XLEN-1:1], 1'b0};
      default:                next_pc = pc_plus4;
    endcase
  end

endmodule

/* src/rv_memwb.sv */
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_memwb (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 run,
  input  logic [`RV_XLEN-1:0]  pc,
  input  logic [4:0]           rd,
  input  logic                 reg_we,
  input  logic                 mem_we,
  input  rv_ctrl_pkg::wb_sel_t wb_sel,
  input  logic [`RV_XLEN-1:0]  alu_result,
  input  logic [`RV_XLEN-1:0]  rs2_val,
  input  logic [`RV_XLEN-1:0]  pc_plus4,
  output logic [`RV_XLEN-1:0]  wb_data,
  output logic                 rf_we,
  output logic                 retire_valid,
  output logic [`RV_XLEN-1:0]  retire_pc,
  output logic [4:0]           retire_rd,
  output logic [`RV_XLEN-1:0]  retire_data
);

  localparam int DMEM_AW = $clog2(`RV_DMEM_WORDS);

  logic [`RV_XLEN-1:0] dmem [`RV_DMEM_WORDS];
  logic [`RV_XLEN-1:0] mem_rdata;
  logic [DMEM_AW-1:0]  mem_idx;
  logic                rd_written;

  assign mem_idx   = alu_result[DMEM_AW+1:2];
  assign mem_rdata = dmem[mem_idx];

  always_ff @(posedge clk) begin
    if (run && mem_we) begin
      dmem[mem_idx] <= rs2_val;
    end
  end

  always_comb begin
    case (wb_sel)
      rv_ctrl_pkg::WB_MEM: wb_data = mem_rdata;
      rv_ctrl_pkg::WB_PC4: wb_data = pc_plus4;
      default:             wb_data = alu_result;
    endcase
  end

  assign rf_we      = reg_we & run;
  assign rd_written = rf_we && (rd != 5'd0);

  always_ff @(posedge clk) begin
    if (reset) begin
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= run;  // One retire per executing edge
    end
  end

  always_ff @(posedge clk) begin
    if (run) begin
      retire_pc   <= pc;
      retire_rd   <= rd_written ? rd : 5'd0;
      retire_data <= rd_written ? wb_data : '0;
    end
  end

  // Address comes from the ALU, so check word alignment and range here
  mem_access_a: assert property (@(posedge clk) disable iff (reset)
    (run && (mem_we || wb_sel == rv_ctrl_pkg::WB_MEM)) |->
      (alu_result[1:0] == 2'b00 && alu_result < `RV_DMEM_WORDS * 4));

endmodule

/* src/rv_core.sv */
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_core (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              run,
  input  logic                              load_en,
  input  logic [$clog2(`RV_IMEM_WORDS)-1:0] load_addr,
  input  logic [`RV_XLEN-1:0]               load_data,
  output logic                              retire_valid,
  output logic [`RV_XLEN-1:0]               retire_pc,
  output logic [4:0]                        retire_rd,
  output logic [`RV_XLEN-1:0]               retire_data
);

  logic [`RV_XLEN-1:0]   pc;
  logic [`RV_XLEN-1:0]   pc_plus4;
  logic [`RV_XLEN-1:0]   instr;
  logic [`RV_XLEN-1:0]   next_pc;
  logic [4:0]            rs1;
  logic [4:0]            rs2;
  logic [4:0]            rd;
  logic [2:0]            funct3;
  logic [`RV_XLEN-1:0]   imm;
  rv_ctrl_pkg::alu_op_t  alu_op;
  rv_ctrl_pkg::alu_src_t alu_src;
  rv_ctrl_pkg::wb_sel_t  wb_sel;
  rv_ctrl_pkg::pc_sel_t  pc_sel;
  logic                  reg_we;
  logic                  mem_we;
  logic [`RV_XLEN-1:0]   rs1_val;
  logic [`RV_XLEN-1:0]   rs2_val;
  logic [`RV_XLEN-1:0]   alu_result;
  logic [`RV_XLEN-1:0]   wb_data;
  logic                  rf_we;

  rv_fetch u_fetch (
    .clk, .reset, .run, .load_en, .load_addr, .load_data,
    .next_pc, .pc, .pc_plus4, .instr
  );

  rv_decode u_decode (
    .instr, .rs1, .rs2, .rd, .funct3, .imm,
    .alu_op, .alu_src, .wb_sel, .pc_sel, .reg_we, .mem_we
  );

  // Writes are gated by run inside rv_memwb
  rv_regfile u_regfile (
    .clk, .reset, .rs1, .rs2, .rd,
    .reg_we(rf_we), .wb_data, .rs1_val, .rs2_val
  );

  rv_execute u_execute (
    .pc, .pc_plus4, .imm, .rs1_val, .rs2_val,
    .alu_op, .alu_src, .funct3, .pc_sel, .alu_result, .next_pc
  );

  rv_memwb u_memwb (
    .clk, .reset, .run, .pc, .rd, .reg_we, .mem_we, .wb_sel,
    .alu_result, .rs2_val, .pc_plus4, .wb_data, .rf_we,
    .retire_valid, .retire_pc, .retire_rd, .retire_data
  );

endmodule

/* verif/rv_clkgen.sv */
`timescale 1ns/1ps

module rv_clkgen #(
  parameter real PERIOD_NS = 4.0
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #(PERIOD_NS / 2.0) clk = ~clk;

endmodule

/* verif/rv_core_tb.sv */
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_core_tb;

  localparam int IMEM_AW      = $clog2(`RV_IMEM_WORDS);
  localparam int RESET_CYCLES = 16;

  logic               clk;
  logic               reset;
  logic               run;
  logic               load_en;
  logic [IMEM_AW-1:0] load_addr;
  logic [31:0]        load_data;
  logic               retire_valid;
  logic [31:0]        retire_pc;
  logic [4:0]         retire_rd;
  logic [31:0]        retire_data;

  logic [31:0] prog [$];  // Program image, also read by the ISS
  logic [31:0] m_regs [32];
  logic [31:0] m_dmem [`RV_DMEM_WORDS];
  logic [31:0] m_pc;
  logic [15:0] lfsr = 16'd63;
  logic        run_at_edge = 1'b0;
  logic        edge_seen = 1'b0;
  int          retired;
  int          cycle_count = 0;
  int          cycle_limit = 0;

  logic [2:0] alu_f3 [6] = '{rv_isa_pkg::F3_ADD, rv_isa_pkg::F3_SLL, rv_isa_pkg::F3_XOR,
                             rv_isa_pkg::F3_SRL, rv_isa_pkg::F3_OR, rv_isa_pkg::F3_AND};
  logic [2:0] br_f3 [4] = '{rv_isa_pkg::F3_BEQ, rv_isa_pkg::F3_BNE,
                            rv_isa_pkg::F3_BLT, rv_isa_pkg::F3_BGE};

  rv_clkgen #(.PERIOD_NS(4.0)) clk_gen (.clk(clk));

  rv_core uut (
    .clk, .reset, .run, .load_en, .load_addr, .load_data,
    .retire_valid, .retire_pc, .retire_rd, .retire_data
  );

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OP_ARITH};
  endfunction

  function automatic logic [31:0] i_type(logic [6:0] op, logic [11:0] imm, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_isa_pkg::OP_STORE};  // Word access
  endfunction

  function automatic logic [31:0] b_type(logic [12:0] off, logic [4:0] rs1, logic [4:0] rs2,
                                         logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_isa_pkg::OP_BRANCH};
  endfunction

  function automatic logic [31:0] j_type(logic [20:0] off, logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, rv_isa_pkg::OP_JAL};
  endfunction

  // Reference ISS, one instruction per call
  function automatic void iss_step(output logic [31:0] e_pc, output logic [4:0] e_rd,
                                   output logic [31:0] e_data);
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] op_b;
    logic [31:0] diff;
    logic [31:0] res;
    logic [31:0] nxt;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic        wr;
    logic        taken;
    ins   = prog[m_pc >> 2];
    a     = m_regs[ins[19:15]];
    b     = m_regs[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    op_b  = (ins[6:0] == rv_isa_pkg::OP_ARITH) ? b : imm_i;
    diff  = a - b;
    wr    = 1'b0;
    taken = 1'b0;
    res   = '0;
    nxt   = m_pc + 32'd4;
    case (ins[6:0])
      rv_isa_pkg::OP_ARITH, rv_isa_pkg::OP_ARITH_IMM: begin
        wr = 1'b1;
        case (ins[14:12])
          rv_isa_pkg::F3_SLL: res = a << op_b[4:0];
          rv_isa_pkg::F3_XOR: res = a ^ op_b;
          rv_isa_pkg::F3_SRL: res = a >> op_b[4:0];
          rv_isa_pkg::F3_OR:  res = a | op_b;
          rv_isa_pkg::F3_AND: res = a & op_b;
          default:            res = a + op_b;
        endcase
        if (ins[6:0] == rv_isa_pkg::OP_ARITH && ins[31:25] == rv_isa_pkg::F7_SUB) begin
          res = a - b;  // funct7 overrides funct3
        end
      end
      rv_isa_pkg::OP_LOAD: begin
        wr  = 1'b1;
        res = m_dmem[((a + imm_i) >> 2) % `RV_DMEM_WORDS];
      end
      rv_isa_pkg::OP_STORE: m_dmem[((a + imm_s) >> 2) % `RV_DMEM_WORDS] = b;
      rv_isa_pkg::OP_BRANCH: begin
        case (ins[14:12])
          rv_isa_pkg::F3_BEQ: taken = (diff == '0);
          rv_isa_pkg::F3_BNE: taken = (diff != '0);
          rv_isa_pkg::F3_BLT: taken = diff[31];  // Sign bit only
          rv_isa_pkg::F3_BGE: taken = !diff[31];
          default:            taken = 1'b0;
        endcase
        if (taken) begin
          nxt = m_pc + imm_b;
        end
      end
      rv_isa_pkg::OP_JAL: begin
        wr  = 1'b1;
        res = m_pc + 32'd4;
        nxt = m_pc + imm_j;
      end
      rv_isa_pkg::OP_JALR: begin
        wr  = 1'b1;
        res = m_pc + 32'd4;
        nxt = (a + imm_i) & ~32'd1;
      end
      default: ;
    endcase
    e_pc   = m_pc;
    e_rd   = (wr && ins[11:7] != 5'd0) ? ins[11:7] : 5'd0;
    e_data = (e_rd != 5'd0) ? res : '0;
    if (e_rd != 5'd0) begin
      m_regs[e_rd] = res;
    end
    m_pc = nxt;
  endfunction

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  always @(posedge clk) begin
    run_at_edge <= run && !reset;
    edge_seen   <= 1'b1;
  end

  // Retire outputs are stable at the falling edge
  always @(negedge clk) begin : compare
    logic [31:0] e_pc;
    logic [4:0]  e_rd;
    logic [31:0] e_data;
    if (edge_seen) begin
      check_value("retire_valid", 32'(retire_valid), 32'(run_at_edge));
      if (retire_valid) begin
        iss_step(e_pc, e_rd, e_data);
        check_value("retire_pc", retire_pc, e_pc);
        check_value("retire_rd", 32'(retire_rd), 32'(e_rd));
        check_value("retire_data", retire_data, e_data);
        retired++;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("Timeout: the retire trace stalled after %0d cycles", cycle_count);
      $display("Test failed");
      $fatal(1);
    end
  end

  task automatic build_directed();
    logic [31:0] skip;
    skip = i_type(rv_isa_pkg::OP_ARITH_IMM, 12'd1, 5'd0, rv_isa_pkg::F3_ADD, 5'd21);
    prog.delete();
    prog.push_back(i_type(rv_isa_pkg::OP_ARITH_IMM, 12'h123, 5'd0, rv_isa_pkg::F3_ADD, 5'd1));
    prog.push_back(i_type(rv_isa_pkg::OP_ARITH_IMM, 12'hffb, 5'd0, rv_isa_pkg::F3_ADD, 5'd2));
    for (int k = 0; k < 6; k++) begin
      prog.push_back(r_type(7'd0, 5'd2, 5'd1, alu_f3[k], 5'(3 + k)));  // x2 shifts by 27
      prog.push_back(i_type(rv_isa_pkg::OP_ARITH_IMM, (k == 1 || k == 3) ? 12'd13 : 12'h9a5,
                            5'd2, alu_f3[k], 5'(9 + k)));
    end
    prog.push_back(r_type(rv_isa_pkg::F7_SUB, 5'd2, 5'd1, rv_isa_pkg::F3_ADD, 5'd15));
    prog.push_back(r_type(rv_isa_pkg::F7_SUB, 5'd1, 5'd2, rv_isa_pkg::F3_ADD, 5'd16));
    prog.push_back(i_type(rv_isa_pkg::OP_ARITH_IMM, 12'd7, 5'd1, rv_isa_pkg::F3_ADD, 5'd0));
    prog.push_back(r_type(7'd0, 5'd2, 5'd1, rv_isa_pkg::F3_OR, 5'd0));
    prog.push_back(r_type(7'd0, 5'd0, 5'd0, rv_isa_pkg::F3_ADD, 5'd17));
    prog.push_back(s_type(12'd8, 5'd1, 5'd0));
    prog.push_back(s_type(12'd12, 5'd2, 5'd0));
    prog.push_back(i_type(rv_isa_pkg::OP_LOAD, 12'd8, 5'd0, 3'b010, 5'd18));
    prog.push_back(i_type(rv_isa_pkg::OP_LOAD, 12'd12, 5'd0, 3'b010, 5'd19));
    prog.push_back(s_type(12'd12, 5'd18, 5'd0));  // Overwrite word 3
    prog.push_back(i_type(rv_isa_pkg::OP_LOAD, 12'd12, 5'd0, 3'b010, 5'd20));
    // Untaken, taken, then the skipped slot
    prog.push_back(b_type(13'd8, 5'd1, 5'd2, rv_isa_pkg::F3_BEQ));
    prog.push_back(b_type(13'd8, 5'd1, 5'd1, rv_isa_pkg::F3_BEQ));
    prog.push_back(skip);
    prog.push_back(b_type(13'd8, 5'd1, 5'd1, rv_isa_pkg::F3_BNE));
    prog.push_back(b_type(13'd8, 5'd1, 5'd2, rv_isa_pkg::F3_BNE));
    prog.push_back(skip);
    prog.push_back(b_type(13'd8, 5'd1, 5'd2, rv_isa_pkg::F3_BLT));
    prog.push_back(b_type(13'd8, 5'd2, 5'd1, rv_isa_pkg::F3_BLT));
    prog.push_back(skip);
    prog.push_back(b_type(13'd8, 5'd2, 5'd1, rv_isa_pkg::F3_BGE));
    prog.push_back(b_type(13'd8, 5'd1, 5'd2, rv_isa_pkg::F3_BGE));
    prog.push_back(skip);
    prog.push_back(j_type(21'd8, 5'd22));
    prog.push_back(skip);
    prog.push_back(i_type(rv_isa_pkg::OP_JALR, 12'((prog.size() + 3) * 4 + 1), 5'd0,
                          3'b000, 5'd23));  // Odd target, bit 0 dropped
    prog.push_back(skip);
    prog.push_back(skip);
    prog.push_back(r_type(7'd0, 5'd23, 5'd22, rv_isa_pkg::F3_ADD, 5'd24));
    prog.push_back(j_type(21'd0, 5'd0));
  endtask

  task automatic gen_random(int n);
    int          kind;
    int          sel;
    int          tgt;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    prog.delete();
    for (int w = 0; w < 8; w++) begin
      prog.push_back(s_type(12'(w * 4), 5'd0, 5'd0));  // Defined data for later loads
    end
    for (int i = 8; i < n - 1; i++) begin
      kind = int'(rand_bits(4));
      sel  = int'(rand_bits(3));
      rd   = 5'(rand_bits(3));
      rs1  = 5'(rand_bits(3));
      rs2  = 5'(rand_bits(3));
      imm  = 12'(rand_bits(12));
      tgt  = i + 1 + int'(rand_bits(6)) % (n - 1 - i);  // Forward only
      if (kind < 6) begin
        prog.push_back(r_type(sel > 5 ? rv_isa_pkg::F7_SUB : 7'd0, rs2, rs1,
                              alu_f3[sel > 5 ? 0 : sel], rd));
      end else if (kind < 10) begin
        sel = sel % 6;
        prog.push_back(i_type(rv_isa_pkg::OP_ARITH_IMM,
                              (sel == 1 || sel == 3) ? {7'd0, imm[4:0]} : imm,
                              rs1, alu_f3[sel], rd));
      end else if (kind == 10) begin
        prog.push_back(i_type(rv_isa_pkg::OP_LOAD, {7'd0, imm[2:0], 2'b00}, 5'd0, 3'b010, rd));
      end else if (kind == 11) begin
        prog.push_back(s_type({7'd0, imm[2:0], 2'b00}, rs2, 5'd0));
      end else if (kind < 14) begin
        prog.push_back(b_type(13'((tgt - i) * 4), rs1, rs2, br_f3[sel % 4]));
      end else if (kind == 14) begin
        prog.push_back(j_type(21'((tgt - i) * 4), rd));
      end else begin
        prog.push_back(i_type(rv_isa_pkg::OP_JALR, 12'(tgt * 4 + int'(imm[0])), 5'd0,
                              3'b000, rd));
      end
    end
    prog.push_back(j_type(21'd0, 5'd0));  // Park on a jump to itself
  endtask

  task automatic run_test(int n_retires, bit random_run);
    int issued;
    issued      = 0;
    cycle_limit = cycle_limit + (prog.size() + n_retires + RESET_CYCLES) * 3 / 2;
    m_pc        = `RV_RESET_PC;
    foreach (m_regs[r]) begin
      m_regs[r] = '0;
    end
    retired = 0;
    @(posedge clk);
    #1;
    reset = 1'b1;
    foreach (prog[i]) begin
      load_en   = 1'b1;
      load_addr = IMEM_AW'(i);
      load_data = prog[i];
      @(posedge clk);
      #1;
    end
    load_en = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;
    repeat (4) @(posedge clk);  // Run still low, no retire expected
    while (issued < n_retires) begin
      @(posedge clk);
      #1;
      run = random_run ? (rand_bits(2) != 0) : 1'b1;
      if (run) begin
        issued++;
      end
    end
    @(posedge clk);
    #1;
    run = 1'b0;
    wait (retired == n_retires);
  endtask

  initial begin
    reset     = 1'b1;
    run       = 1'b0;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    build_directed();
    run_test(50, 1'b0);
    for (int t = 0; t < 3; t++) begin
      gen_random(40);
      run_test(60, 1'b1);
    end
    $display("Test passed");
    $finish;
  end

endmodule

/* rv_core.f */
+incdir+src
src/rv_isa_pkg.sv
src/rv_ctrl_pkg.sv
src/rv_fetch.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_execute.sv
src/rv_memwb.sv
src/rv_core.sv
verif/rv_clkgen.sv
verif/rv_core_tb.sv
